/* common/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// ============================================================
// Decode stage widths
// ============================================================

// Raw instruction word as delivered by fetch
`define ID_INSN_LEN 32

// Architectural register index, x0 to x31
`define ID_REG_SEL 5

// ============================================================
// Dispatch flow control
// ============================================================

// Dispatch buffer entries seen by the decode stage
// Any value from 1 to 15 fits the counter below
`define ID_DISPATCH_CREDITS 4

// Credit counter width
// Must be able to hold ID_DISPATCH_CREDITS itself
`define ID_CREDIT_W 4

// One credit comes back per freed dispatch entry
// Counter starts full after reset

`endif

/* common/id_pkg.sv */
`include "id_config.svh"

package id_pkg;

  // ============================================================
  // Basic field types
  // ============================================================

  typedef logic [`ID_INSN_LEN-1:0] insn_t;   // One fetched instruction
  typedef logic [`ID_REG_SEL-1:0]  reg_sel_t; // Register index

  // Major opcodes of RV32IM, bits [6:0]
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // ============================================================
  // Decode control enums
  // ============================================================

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE
  } imm_type_e;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
  } src_a_sel_e;

  typedef enum logic [1:0] {
    SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR
  } src_b_sel_e;

  // Compare ops feed the branch unit
  typedef enum logic [3:0] {
    ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
    ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND,
    ALU_OP_SEQ, ALU_OP_SNE, ALU_OP_SGE, ALU_OP_SGEU
  } alu_op_e;

  // Target reservation station, NONE is zero
  typedef enum logic [2:0] {
    RS_ENT_NONE, RS_ENT_ALU, RS_ENT_BRANCH, RS_ENT_LDST, RS_ENT_MULDIV
  } rs_ent_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
  } mem_type_e;

  typedef enum logic [1:0] {
    MD_OP_MUL, MD_OP_DIV, MD_OP_REM
  } md_op_e;

  typedef enum logic {
    MD_OUT_LO, MD_OUT_HI
  } md_out_sel_e;

  // ============================================================
  // Records
  // ============================================================

  typedef struct packed {
    imm_type_e   imm_type;
    reg_sel_t    rs1;
    reg_sel_t    rs2;
    reg_sel_t    rd;
    src_a_sel_e  src_a_sel;
    src_b_sel_e  src_b_sel;
    logic        wr_reg;        // Writes rd, never for x0
    logic        uses_rs1;
    logic        uses_rs2;
    logic        illegal;
    alu_op_e     alu_op;
    rs_ent_e     rs_ent;
    logic [2:0]  dmem_size;     // funct3 of loads and stores
    mem_type_e   dmem_type;
    md_op_e      md_op;
    logic        md_in1_signed;
    logic        md_in2_signed;
    md_out_sel_e md_out_sel;
  } decode_info_t;

  // Dispatch bundle, slot1 all zero when not valid
  typedef struct packed {
    decode_info_t slot0;
    decode_info_t slot1;
    logic         slot1_valid;
    logic         rs1_2_eq_dst1; // slot1 rs1 reads slot0 rd
    logic         rs2_2_eq_dst1; // slot1 rs2 reads slot0 rd
  } id_bundle_t;

endpackage

/* decoder/rv32_decoder.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module rv32_decoder (
  input  logic [`ID_INSN_LEN-1:0] inst_i,
  output id_pkg::decode_info_t    info_o
);

  // ============================================================
  // Instruction fields
  // ============================================================

  id_pkg::opcode_e        opcode;
  logic [`ID_REG_SEL-1:0] rd;
  logic [`ID_REG_SEL-1:0] rs1;
  logic [`ID_REG_SEL-1:0] rs2;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  id_pkg::decode_info_t   info;

  assign opcode = id_pkg::opcode_e'(inst_i[6:0]);
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  // ============================================================
  // Main decode
  // ============================================================

  always_comb begin
    info               = '0;
    info.imm_type      = id_pkg::IMM_NONE;
    info.rs1           = rs1;           // Register fields pass straight through
    info.rs2           = rs2;
    info.rd            = rd;
    info.src_a_sel     = id_pkg::SRC_A_RS1;
    info.src_b_sel     = id_pkg::SRC_B_IMM;
    info.alu_op        = id_pkg::ALU_OP_ADD;
    info.rs_ent        = id_pkg::RS_ENT_NONE;
    info.dmem_size     = funct3;
    info.dmem_type     = id_pkg::MEM_NONE;
    info.md_op         = id_pkg::MD_OP_MUL;
    info.md_out_sel    = id_pkg::MD_OUT_LO;

    case (opcode)
      id_pkg::OPC_LUI: begin
        info.imm_type  = id_pkg::IMM_U;
        info.src_a_sel = id_pkg::SRC_A_ZERO;  // 0 + imm
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_ALU;
      end
      id_pkg::OPC_AUIPC: begin
        info.imm_type  = id_pkg::IMM_U;
        info.src_a_sel = id_pkg::SRC_A_PC;    // pc + imm
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_ALU;
      end
      id_pkg::OPC_JAL: begin
        info.imm_type  = id_pkg::IMM_J;
        info.src_a_sel = id_pkg::SRC_A_PC;
        info.src_b_sel = id_pkg::SRC_B_FOUR;  // Link value pc + 4
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_BRANCH;
      end
      id_pkg::OPC_JALR: begin
        info.imm_type  = id_pkg::IMM_I;
        info.src_a_sel = id_pkg::SRC_A_PC;
        info.src_b_sel = id_pkg::SRC_B_FOUR;
        info.uses_rs1  = 1'b1;                // Target base
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_BRANCH;
        info.illegal   = (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        info.imm_type  = id_pkg::IMM_B;
        info.src_b_sel = id_pkg::SRC_B_RS2;   // Compare rs1 with rs2
        info.uses_rs1  = 1'b1;
        info.uses_rs2  = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_BRANCH;
        case (funct3)
          3'b000:  info.alu_op = id_pkg::ALU_OP_SEQ;  // BEQ
          3'b001:  info.alu_op = id_pkg::ALU_OP_SNE;  // BNE
          3'b100:  info.alu_op = id_pkg::ALU_OP_SLT;  // BLT
          3'b101:  info.alu_op = id_pkg::ALU_OP_SGE;  // BGE
          3'b110:  info.alu_op = id_pkg::ALU_OP_SLTU; // BLTU
          3'b111:  info.alu_op = id_pkg::ALU_OP_SGEU; // BGEU
          default: info.illegal = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        info.imm_type  = id_pkg::IMM_I;
        info.uses_rs1  = 1'b1;
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_LDST;
        info.dmem_type = id_pkg::MEM_LOAD;
        // LB LH LW LBU LHU only
        info.illegal   = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      id_pkg::OPC_STORE: begin
        info.imm_type  = id_pkg::IMM_S;
        info.uses_rs1  = 1'b1;                // Address base
        info.uses_rs2  = 1'b1;                // Store data
        info.rs_ent    = id_pkg::RS_ENT_LDST;
        info.dmem_type = id_pkg::MEM_STORE;
        info.illegal   = (funct3[2] == 1'b1) || (funct3[1:0] == 2'b11);
      end
      id_pkg::OPC_OP_IMM: begin
        info.imm_type  = id_pkg::IMM_I;
        info.uses_rs1  = 1'b1;
        info.wr_reg    = 1'b1;
        info.rs_ent    = id_pkg::RS_ENT_ALU;
        case (funct3)
          3'b000: info.alu_op = id_pkg::ALU_OP_ADD;
          3'b010: info.alu_op = id_pkg::ALU_OP_SLT;
          3'b011: info.alu_op = id_pkg::ALU_OP_SLTU;
          3'b100: info.alu_op = id_pkg::ALU_OP_XOR;
          3'b110: info.alu_op = id_pkg::ALU_OP_OR;
          3'b111: info.alu_op = id_pkg::ALU_OP_AND;
          3'b001: begin                       // SLLI, shamt in rs2 field
            info.alu_op  = id_pkg::ALU_OP_SLL;
            info.illegal = (funct7 != 7'b0000000);
          end
          default: begin                      // SRLI or SRAI
            info.alu_op  = funct7[5] ? id_pkg::ALU_OP_SRA : id_pkg::ALU_OP_SRL;
            info.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      id_pkg::OPC_OP: begin
        info.src_b_sel = id_pkg::SRC_B_RS2;
        info.uses_rs1  = 1'b1;
        info.uses_rs2  = 1'b1;
        info.wr_reg    = 1'b1;
        if (funct7 == 7'b0000001) begin
          // M extension
          info.rs_ent        = id_pkg::RS_ENT_MULDIV;
          info.md_op         = funct3[2] ? (funct3[1] ? id_pkg::MD_OP_REM : id_pkg::MD_OP_DIV)
                                         : id_pkg::MD_OP_MUL;
          info.md_out_sel    = (funct3 == 3'b000) ? id_pkg::MD_OUT_LO : id_pkg::MD_OUT_HI;
          info.md_in1_signed = funct3[2] ? ~funct3[0] : (funct3[1:0] != 2'b11);
          info.md_in2_signed = funct3[2] ? ~funct3[0] : (funct3[1:0] == 2'b01 ||
                                                         funct3[1:0] == 2'b00);
          if (funct3[2]) begin
            info.md_out_sel  = id_pkg::MD_OUT_LO;     // Quotient or remainder
          end
        end else if (funct7 == 7'b0000000) begin
          info.rs_ent = id_pkg::RS_ENT_ALU;
          case (funct3)
            3'b000:  info.alu_op = id_pkg::ALU_OP_ADD;
            3'b001:  info.alu_op = id_pkg::ALU_OP_SLL;
            3'b010:  info.alu_op = id_pkg::ALU_OP_SLT;
            3'b011:  info.alu_op = id_pkg::ALU_OP_SLTU;
            3'b100:  info.alu_op = id_pkg::ALU_OP_XOR;
            3'b101:  info.alu_op = id_pkg::ALU_OP_SRL;
            3'b110:  info.alu_op = id_pkg::ALU_OP_OR;
            default: info.alu_op = id_pkg::ALU_OP_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          info.rs_ent  = id_pkg::RS_ENT_ALU;
          info.alu_op  = (funct3 == 3'b101) ? id_pkg::ALU_OP_SRA : id_pkg::ALU_OP_SUB;
          info.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          info.illegal = 1'b1;
        end
      end
      id_pkg::OPC_MISC_MEM: begin
        // FENCE runs as a no-op in an in-order front end
        info.rs_ent = id_pkg::RS_ENT_NONE;
      end
      default: info.illegal = 1'b1;   // SYSTEM and unknown opcodes
    endcase

    // Illegal encodings never write or issue
    if (info.illegal) begin
      info.wr_reg = 1'b0;
      info.rs_ent = id_pkg::RS_ENT_NONE;
    end
    if (rd == '0) begin
      info.wr_reg = 1'b0;             // x0 is hardwired
    end
  end

  assign info_o = info;

endmodule

/* source/id_dispatch_latch.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module id_dispatch_latch (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 fetch_valid_i,
  input  logic                 inst1_valid_i,
  input  logic                 kill_i,
  input  logic                 credit_return_i,
  input  id_pkg::decode_info_t info0_i,
  input  id_pkg::decode_info_t info1_i,
  output logic                 fetch_ready_o,
  output id_pkg::id_bundle_t   bundle_o,
  output logic                 bundle_valid_o
);

  localparam int unsigned CREDIT_W = `ID_CREDIT_W;
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`ID_DISPATCH_CREDITS);

  logic [CREDIT_W-1:0] credit_q;      // Free dispatch entries
  logic                accept;
  logic                slot0_writes;
  logic                dep_rs1;
  logic                dep_rs2;
  id_pkg::id_bundle_t  bundle_d;
  id_pkg::id_bundle_t  bundle_q;
  logic                bundle_valid_q;

  // ============================================================
  // Handshake toward fetch
  // ============================================================

  assign fetch_ready_o = (credit_q != '0);                      // Room downstream
  assign accept        = fetch_valid_i & fetch_ready_o & ~kill_i; // Kill drops the pair

  // ============================================================
  // Pair dependency and bundle assembly
  // ============================================================

  // x0 writes never count as producers
  assign slot0_writes = info0_i.wr_reg & (info0_i.rd != '0);

  assign dep_rs1 = inst1_valid_i & slot0_writes & info1_i.uses_rs1 &
                   (info1_i.rs1 == info0_i.rd);
  assign dep_rs2 = inst1_valid_i & slot0_writes & info1_i.uses_rs2 &
                   (info1_i.rs2 == info0_i.rd);

  always_comb begin
    bundle_d               = '0;
    bundle_d.slot0         = info0_i;
    if (inst1_valid_i) begin
      bundle_d.slot1       = info1_i; // Otherwise left all zero
    end
    bundle_d.slot1_valid   = inst1_valid_i;
    bundle_d.rs1_2_eq_dst1 = dep_rs1;
    bundle_d.rs2_2_eq_dst1 = dep_rs2;
  end

  // ============================================================
  // Credit counter
  // ============================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q <= CREDIT_MAX;         // Dispatch buffer empty
    end else begin
      case ({accept, credit_return_i})
        2'b10:   credit_q <= credit_q - 1'b1; // Entry taken
        2'b01:   credit_q <= credit_q + 1'b1; // Entry freed
        default: credit_q <= credit_q;        // Both or neither
      endcase
    end
  end

  // Stage register toward dispatch
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bundle_valid_q <= 1'b0;
    end else begin
      bundle_valid_q <= accept;       // One bundle per accept, kill clears
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      bundle_q <= bundle_d;
    end
  end

  assign bundle_o       = bundle_q;
  assign bundle_valid_o = bundle_valid_q;

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
  input  logic               clk_i,
  input  logic               reset_i,
  // Fetch side
  input  logic               fetch_valid_i,
  input  id_pkg::insn_t      inst0_i,
  input  id_pkg::insn_t      inst1_i,
  input  logic               inst1_valid_i,
  output logic               fetch_ready_o,
  // Flush and dispatch side
  input  logic               kill_i,
  input  logic               credit_return_i,
  output id_pkg::id_bundle_t bundle_o,
  output logic               bundle_valid_o
);

  id_pkg::decode_info_t info0;        // Older instruction
  id_pkg::decode_info_t info1;        // Younger instruction

  // ============================================================
  // Two decoders side by side
  // ============================================================

  rv32_decoder u_dec0 (
    .inst_i (inst0_i),
    .info_o (info0)
  );

  rv32_decoder u_dec1 (
    .inst_i (inst1_i),
    .info_o (info1)
  );

  // Combine, check dependencies and register toward dispatch
  id_dispatch_latch u_latch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .inst1_valid_i   (inst1_valid_i),
    .kill_i          (kill_i),
    .credit_return_i (credit_return_i),
    .info0_i         (info0),
    .info1_i         (info1),
    .fetch_ready_o   (fetch_ready_o),
    .bundle_o        (bundle_o),
    .bundle_valid_o  (bundle_valid_o)
  );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 20;  // 40 ns period

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

/* bench/id_stage_chk.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module id_stage_chk (
  input logic clk_i,
  input logic reset_i,
  input logic fetch_valid_i,
  input logic kill_i,
  input logic fetch_ready_o,
  input logic credit_return_i,
  input logic bundle_valid_o
);

  localparam int CREDITS = `ID_DISPATCH_CREDITS;

  int   outstanding;                  // Accepted pairs whose credit is still out
  int   fail_count = 0;               // Assertion failures so far
  logic accept;

  assign accept = fetch_valid_i & fetch_ready_o & ~kill_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(accept) - int'(credit_return_i);
    end
  end

  // ============================================================
  // Handshake and credit rules
  // ============================================================

  assert property (@(posedge clk_i) reset_i |=> !bundle_valid_o)
    else begin
      $error("bundle_valid_o high in the cycle after reset");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   (outstanding >= CREDITS) |-> !fetch_ready_o)
    else begin
      $error("fetch_ready_o high with no dispatch credit left");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) outstanding <= CREDITS)
    else begin
      $error("more bundles outstanding than dispatch entries");
      fail_count++;
    end

endmodule

/* bench/tb_id_stage.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id_stage;

  localparam int CREDITS   = `ID_DISPATCH_CREDITS;
  localparam int MAX_LINES = 32;
  localparam int TIMEOUT   = 100;       // Cycles allowed per wait
  localparam int HOLD_LEN  = CREDITS + 4; // Pairs pushed against a stalled dispatch

  logic               clk_i;
  logic               reset_i;
  logic               fetch_valid_i;
  logic               inst1_valid_i;
  logic               kill_i;
  logic               credit_return_i;
  logic               fetch_ready_o;
  logic               bundle_valid_o;
  id_pkg::insn_t      inst0_i;
  id_pkg::insn_t      inst1_i;
  id_pkg::id_bundle_t bundle_o;

  // Trace contents, one entry per pair
  logic [31:0] tr_inst0 [MAX_LINES];
  logic [31:0] tr_inst1 [MAX_LINES];
  int          tr_v1    [MAX_LINES];
  int          tr_kill  [MAX_LINES];
  int          exp_f    [MAX_LINES][12];
  int          num_lines;
  string       field_name [12] = '{
    "slot0.alu_op", "slot0.rs_ent", "slot0.rd", "slot0.wr_reg", "slot0.illegal",
    "slot1.alu_op", "slot1.rs_ent", "slot1.rd", "slot1.wr_reg", "slot1.illegal",
    "rs1_2_eq_dst1", "rs2_2_eq_dst1"
  };

  int         exp_q [$];               // Trace index per accepted pair
  int         pending_q [$];           // Hold cycles per bundle in dispatch
  int         cur_idx      = 0;
  int         free_credits = CREDITS;  // Model of the DUT counter
  int         hold_accepts = 0;
  logic       accept_last  = 1'b0;
  logic       checking     = 1'b0;
  logic       hold_credits = 1'b0;     // Dispatch stalls all returns
  logic [7:0] lfsr_q       = 8'd31;

  tb_clock_gen u_clk (.clk_o (clk_i));

  id_stage DUT (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .inst0_i         (inst0_i),
    .inst1_i         (inst1_i),
    .inst1_valid_i   (inst1_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .kill_i          (kill_i),
    .credit_return_i (credit_return_i),
    .bundle_o        (bundle_o),
    .bundle_valid_o  (bundle_valid_o)
  );

  bind id_stage id_stage_chk u_chk (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .kill_i          (kill_i),
    .fetch_ready_o   (fetch_ready_o),
    .credit_return_i (credit_return_i),
    .bundle_valid_o  (bundle_valid_o)
  );

  // ============================================================
  // Helpers
  // ============================================================

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns %s", $time, why);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  // Galois LFSR, taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    lfsr_step = s >> 1;
    if (s[0]) lfsr_step = lfsr_step ^ 8'hB8;
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v      = (v << 1) | lfsr_q[0];   // One step per bit
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic load_trace();
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/id_trace.txt", "r");
    if (fd == 0) abort_run("could not open the trace file bench/id_trace.txt");
    num_lines = 0;
    while (!$feof(fd) && num_lines < MAX_LINES) begin
      line = "";
      n    = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin   // Skip comments and blanks
        n = $sscanf(line, "%h %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    tr_inst0[num_lines], tr_inst1[num_lines],
                    tr_v1[num_lines], tr_kill[num_lines],
                    exp_f[num_lines][0], exp_f[num_lines][1], exp_f[num_lines][2],
                    exp_f[num_lines][3], exp_f[num_lines][4], exp_f[num_lines][5],
                    exp_f[num_lines][6], exp_f[num_lines][7], exp_f[num_lines][8],
                    exp_f[num_lines][9], exp_f[num_lines][10], exp_f[num_lines][11]);
        if (n != 16) abort_run("malformed line in the trace file");
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_bundle(input int idx);
    int got [12];
    got[0]  = bundle_o.slot0.alu_op;
    got[1]  = bundle_o.slot0.rs_ent;
    got[2]  = bundle_o.slot0.rd;
    got[3]  = bundle_o.slot0.wr_reg;
    got[4]  = bundle_o.slot0.illegal;
    got[5]  = bundle_o.slot1.alu_op;
    got[6]  = bundle_o.slot1.rs_ent;
    got[7]  = bundle_o.slot1.rd;
    got[8]  = bundle_o.slot1.wr_reg;
    got[9]  = bundle_o.slot1.illegal;
    got[10] = bundle_o.rs1_2_eq_dst1;
    got[11] = bundle_o.rs2_2_eq_dst1;
    for (int k = 0; k < 12; k++) begin
      check_value(field_name[k], got[k], exp_f[idx][k]);
    end
    check_value("slot1_valid", bundle_o.slot1_valid, tr_v1[idx] != 0);
    if (tr_v1[idx] == 0) check_value("slot1", bundle_o.slot1, '0); // Empty slot
  endtask

  // Present one pair, kill pairs stay up for a single cycle
  task automatic send_pair(input int idx);
    int waited;
    @(posedge clk_i);
    #2;
    cur_idx       = idx;
    fetch_valid_i = 1'b1;
    inst0_i       = tr_inst0[idx];
    inst1_i       = tr_inst1[idx];
    inst1_valid_i = (tr_v1[idx] != 0);
    kill_i        = (tr_kill[idx] != 0);
    waited        = 0;
    @(negedge clk_i);
    while (!fetch_ready_o && !kill_i) begin
      waited++;
      if (waited > TIMEOUT) abort_run("fetch_ready_o stayed low, pair never accepted");
      @(negedge clk_i);
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    #2;
    fetch_valid_i = 1'b0;
    kill_i        = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (exp_q.size() != 0 || free_credits != CREDITS) begin
      waited++;
      if (waited > TIMEOUT) abort_run("dispatch did not drain, credits still outstanding");
      @(posedge clk_i);
    end
  endtask

  // ============================================================
  // Fetch side monitor and scoreboard, sampled mid-cycle
  // ============================================================

  always @(negedge clk_i) begin : monitor
    int   idx;
    logic accept_now;
    if (checking) begin
      check_value("fetch_ready_o", fetch_ready_o, free_credits != 0);
      check_value("bundle_valid_o", bundle_valid_o, accept_last);  // One cycle latency
      if (bundle_valid_o) begin
        if (exp_q.size() == 0) abort_run("bundle arrived with no accepted pair waiting");
        idx = exp_q.pop_front();
        compare_bundle(idx);
        pending_q.push_back(draw_bits(3));  // Dispatch holds it 0 to 7 cycles
      end
      accept_now = fetch_valid_i && fetch_ready_o && !kill_i;
      if (accept_now) begin
        exp_q.push_back(cur_idx);
        if (hold_credits) hold_accepts++;
      end
      if (hold_credits && !fetch_ready_o) begin
        check_value("hold_accepts", hold_accepts, CREDITS);  // Full buffer reached
        hold_credits = 1'b0;
      end
      if (accept_now) free_credits--;
      if (credit_return_i) free_credits++;
      accept_last = accept_now;
    end
  end

  // Bound checker counts its assertion failures
  always @(negedge clk_i) begin
    if (DUT.u_chk.fail_count != 0) abort_run("an assertion in the bound checker failed");
  end

  // Dispatch model, frees the oldest entry when its hold time runs out
  always @(posedge clk_i) begin
    #2;
    credit_return_i = 1'b0;
    if (!hold_credits && pending_q.size() != 0) begin
      if (pending_q[0] == 0) begin
        credit_return_i = 1'b1;
        void'(pending_q.pop_front());
      end else begin
        pending_q[0] = pending_q[0] - 1;
      end
    end
  end

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    reset_i         = 1'b1;
    fetch_valid_i   = 1'b0;
    inst0_i         = '0;
    inst1_i         = '0;
    inst1_valid_i   = 1'b0;
    kill_i          = 1'b0;
    credit_return_i = 1'b0;
    load_trace();
    repeat (4) @(posedge clk_i);
    #2;
    reset_i  = 1'b0;
    checking = 1'b1;                     // First sample checks the reset state

    // Whole trace with random dispatch delays
    for (int i = 0; i < num_lines; i++) begin
      send_pair(i);
    end
    go_idle();
    wait_drained();

    // Back-pressure, dispatch keeps every bundle until the credits run out
    hold_accepts = 0;
    hold_credits = 1'b1;
    for (int i = 0; i < HOLD_LEN; i++) begin
      send_pair(i % num_lines);
    end
    go_idle();
    wait_drained();

    @(negedge clk_i);
    if (DUT.u_chk.fail_count != 0) begin
      abort_run("an assertion in the bound checker failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* bench/id_trace.txt */
# inst0 inst1 (hex) v1 kill | slot0: alu ent rd wr ill | slot1: alu ent rd wr ill | dep1 dep2
# alu ADD=0 SUB=1 SLT=3 XOR=5 SRA=7 OR=8 AND=9 SEQ=10 SGE=12, ent NONE=0 ALU=1 BR=2 LDST=3 MD=4
003100B3 40508233 1 0  0 1 1 1 0   1 1 4 1 0   1 0
00538313 0064C433 1 0  0 1 6 1 0   5 1 8 1 0   0 1
0085A503 00A62223 1 0  0 3 10 1 0  0 3 4 0 0   0 1
00208863 0041D463 1 0  10 2 16 0 0 12 2 8 0 0  0 0
123452B7 008000EF 1 0  0 1 5 1 0   0 2 1 1 0   0 0
00100293 00028337 1 0  0 1 5 1 0   0 1 6 1 0   0 0
029403B3 0273D533 1 0  0 4 7 1 0   0 4 10 1 0  1 1
00033283 201281B3 1 0  0 0 5 0 1   0 0 3 0 1   0 0
003100B3 40508233 1 1  0 0 0 0 0   0 0 0 0 0   0 0
00108093 40508233 0 0  0 1 1 1 0   0 0 0 0 0   0 0
00208033 000001B3 1 0  0 1 0 0 0   0 1 3 1 0   0 0
40365593 00E5A6B3 1 0  7 1 11 1 0  3 1 13 1 0  1 0
000080E7 0011E133 1 0  0 2 1 1 0   8 1 2 1 0   0 1
00014483 0FF4F493 1 0  0 3 9 1 0   9 1 9 1 0   1 0
00000073 00000073 1 1  0 0 0 0 0   0 0 0 0 0   0 0
00000073 0000000F 1 0  0 0 0 0 1   0 0 0 0 0   0 0

/* vlog.f */
+incdir+common
common/id_pkg.sv
decoder/rv32_decoder.sv
source/id_dispatch_latch.sv
source/id_stage.sv
bench/tb_clock_gen.sv
bench/id_stage_chk.sv
bench/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/id_pkg.sv
      - decoder/rv32_decoder.sv
      - source/id_dispatch_latch.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_clock_gen.sv
      - bench/id_stage_chk.sv
      - bench/tb_id_stage.sv
